// File: include/rv_core_config.svh
`ifndef RV_CORE_CONFIG_SVH
`define RV_CORE_CONFIG_SVH

// Data and address width
`define RV_XLEN 32

// Architectural register file
`define RV_REG_COUNT 32
`define RV_REG_INDEX_WIDTH 5

// First fetch address after reset
`define RV_RESET_VECTOR 32'h0000_0000

// PC increment per instruction
`define RV_INSTR_STEP 32'd4

`endif

// File: hw/rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

    // Major opcode, instruction bits 6 to 2
    typedef enum logic [4:0] {
        OPC_LOAD   = 5'b00000,
        OPC_OP_IMM = 5'b00100,
        OPC_AUIPC  = 5'b00101,
        OPC_STORE  = 5'b01000,
        OPC_OP     = 5'b01100,
        OPC_LUI    = 5'b01101,
        OPC_BRANCH = 5'b11000,
        OPC_JALR   = 5'b11001,
        OPC_JAL    = 5'b11011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_op_e;

    // Same encoding as memory_data_size
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } mem_size_e;

    typedef enum logic [1:0] {
        ST_FETCH_REQ,
        ST_FETCH_WAIT,
        ST_EXECUTE,
        ST_MEM_WAIT
    } core_state_e;

endpackage

`default_nettype wire

// File: hw/rv_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_config.svh"

module rv_decoder (
    input  wire [`RV_XLEN-1:0]            instruction,
    output rv_core_pkg::opcode_e           opcode,
    output logic [`RV_REG_INDEX_WIDTH-1:0] rs1_index,
    output logic [`RV_REG_INDEX_WIDTH-1:0] rs2_index,
    output logic [`RV_REG_INDEX_WIDTH-1:0] rd_index,
    output logic [2:0]                     funct3,
    output logic [`RV_XLEN-1:0]            immediate,
    output rv_core_pkg::alu_op_e           alu_op,
    output logic                           alu_use_imm,
    output logic                           writes_rd,
    output logic                           is_load,
    output logic                           is_store,
    output logic                           is_branch,
    output rv_core_pkg::mem_size_e         mem_size,
    output logic                           load_unsigned
);

    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_s;
    logic [`RV_XLEN-1:0] imm_b;
    logic [`RV_XLEN-1:0] imm_u;
    logic [`RV_XLEN-1:0] imm_j;

    assign opcode    = rv_core_pkg::opcode_e'(instruction[6:2]);
    assign rd_index  = instruction[11:7];
    assign funct3    = instruction[14:12];
    assign rs1_index = instruction[19:15];
    assign rs2_index = instruction[24:20];

    assign imm_i = {{21{instruction[31]}}, instruction[30:20]};
    assign imm_s = {{21{instruction[31]}}, instruction[30:25], instruction[11:7]};
    assign imm_b = {{20{instruction[31]}}, instruction[7], instruction[30:25],
                    instruction[11:8], 1'b0};
    assign imm_u = {instruction[31:12], 12'b0};
    assign imm_j = {{12{instruction[31]}}, instruction[19:12], instruction[20],
                    instruction[30:21], 1'b0};

    always_comb begin
        case (opcode)
            rv_core_pkg::OPC_STORE:  immediate = imm_s;
            rv_core_pkg::OPC_BRANCH: immediate = imm_b;
            rv_core_pkg::OPC_LUI,
            rv_core_pkg::OPC_AUIPC:  immediate = imm_u;
            rv_core_pkg::OPC_JAL:    immediate = imm_j;
            default:                 immediate = imm_i;
        endcase
    end

    // Only OP and OP-IMM use funct3, everything else adds
    always_comb begin
        alu_op = rv_core_pkg::ALU_ADD;
        if (opcode == rv_core_pkg::OPC_OP || opcode == rv_core_pkg::OPC_OP_IMM) begin
            case (funct3)
                3'b000: alu_op = (opcode == rv_core_pkg::OPC_OP && instruction[30])
                               ? rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
                3'b001: alu_op = rv_core_pkg::ALU_SLL;
                3'b010: alu_op = rv_core_pkg::ALU_SLT;
                3'b011: alu_op = rv_core_pkg::ALU_SLTU;
                3'b100: alu_op = rv_core_pkg::ALU_XOR;
                3'b101: alu_op = instruction[30] ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
                3'b110: alu_op = rv_core_pkg::ALU_OR;
                default: alu_op = rv_core_pkg::ALU_AND;
            endcase
        end
    end

    assign alu_use_imm = (opcode != rv_core_pkg::OPC_OP) && (opcode != rv_core_pkg::OPC_BRANCH);

    assign is_load   = (opcode == rv_core_pkg::OPC_LOAD);
    assign is_store  = (opcode == rv_core_pkg::OPC_STORE);
    assign is_branch = (opcode == rv_core_pkg::OPC_BRANCH);

    always_comb begin
        case (opcode)
            rv_core_pkg::OPC_LOAD, rv_core_pkg::OPC_OP_IMM, rv_core_pkg::OPC_OP,
            rv_core_pkg::OPC_LUI, rv_core_pkg::OPC_AUIPC,
            rv_core_pkg::OPC_JAL, rv_core_pkg::OPC_JALR: writes_rd = 1'b1;
            default: writes_rd = 1'b0; // Unknown opcodes retire as no-ops
        endcase
    end

    always_comb begin
        case (funct3[1:0])
            2'b00:   mem_size = rv_core_pkg::SIZE_BYTE;
            2'b01:   mem_size = rv_core_pkg::SIZE_HALF;
            default: mem_size = rv_core_pkg::SIZE_WORD;
        endcase
    end

    assign load_unsigned = funct3[2];

endmodule

`default_nettype wire

// File: hw/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_config.svh"

module rv_regfile (
    input  wire                           clock,
    input  wire                           rst_n,
    input  wire [`RV_REG_INDEX_WIDTH-1:0] rs1_index,
    input  wire [`RV_REG_INDEX_WIDTH-1:0] rs2_index,
    output logic [`RV_XLEN-1:0]           rs1_data,
    output logic [`RV_XLEN-1:0]           rs2_data,
    input  wire                           write_enable,
    input  wire [`RV_REG_INDEX_WIDTH-1:0] rd_index,
    input  wire [`RV_XLEN-1:0]            rd_data
);

    logic [`RV_XLEN-1:0] registers [`RV_REG_COUNT];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                registers[i] <= '0;
            end
        end else if (write_enable && rd_index != '0) begin // x0 stays zero
            registers[rd_index] <= rd_data;
        end
    end

    assign rs1_data = registers[rs1_index];
    assign rs2_data = registers[rs2_index];

    write_is_known: assert property (@(posedge clock) disable iff (!rst_n)
        write_enable |-> !$isunknown({rd_index, rd_data}));

endmodule

`default_nettype wire

// File: hw/rv_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_config.svh"

module rv_alu (
    input  wire [`RV_XLEN-1:0]  operand_a,
    input  wire [`RV_XLEN-1:0]  operand_b,
    input  rv_core_pkg::alu_op_e alu_op,
    input  wire [2:0]           funct3,
    output logic [`RV_XLEN-1:0] result,
    output logic                branch_taken
);

    logic [4:0] shamt;
    logic       less_signed;
    logic       less_unsigned;

    assign shamt         = operand_b[4:0];
    assign less_signed   = $signed(operand_a) < $signed(operand_b);
    assign less_unsigned = operand_a < operand_b;

    always_comb begin
        case (alu_op)
            rv_core_pkg::ALU_SUB:  result = operand_a - operand_b;
            rv_core_pkg::ALU_SLT:  result = {31'b0, less_signed};
            rv_core_pkg::ALU_SLTU: result = {31'b0, less_unsigned};
            rv_core_pkg::ALU_XOR:  result = operand_a ^ operand_b;
            rv_core_pkg::ALU_OR:   result = operand_a | operand_b;
            rv_core_pkg::ALU_AND:  result = operand_a & operand_b;
            rv_core_pkg::ALU_SLL:  result = operand_a << shamt;
            rv_core_pkg::ALU_SRL:  result = operand_a >> shamt;
            rv_core_pkg::ALU_SRA:  result = $unsigned($signed(operand_a) >>> shamt);
            default:               result = operand_a + operand_b;
        endcase
    end

    // Branch kind from funct3
    always_comb begin
        case (funct3)
            3'b000:  branch_taken = (operand_a == operand_b);
            3'b001:  branch_taken = (operand_a != operand_b);
            3'b100:  branch_taken = less_signed;
            3'b101:  branch_taken = !less_signed;
            3'b110:  branch_taken = less_unsigned;
            3'b111:  branch_taken = !less_unsigned;
            default: branch_taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/rv_lsu.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_config.svh"

module rv_lsu (
    input  rv_core_pkg::mem_size_e mem_size,
    input  wire                    load_unsigned,
    input  wire [`RV_XLEN-1:0]     store_source,
    input  wire [`RV_XLEN-1:0]     memory_data_in,
    output logic [`RV_XLEN-1:0]    store_data,
    output logic [`RV_XLEN-1:0]    load_data
);

    logic byte_fill;
    logic half_fill;

    // Sign bit of the loaded field, zero for unsigned loads
    assign byte_fill = !load_unsigned && memory_data_in[7];
    assign half_fill = !load_unsigned && memory_data_in[15];

    always_comb begin
        case (mem_size)
            rv_core_pkg::SIZE_BYTE: store_data = {24'b0, store_source[7:0]};
            rv_core_pkg::SIZE_HALF: store_data = {16'b0, store_source[15:0]};
            default:                store_data = store_source;
        endcase
    end

    always_comb begin
        case (mem_size)
            rv_core_pkg::SIZE_BYTE: load_data = {{24{byte_fill}}, memory_data_in[7:0]};
            rv_core_pkg::SIZE_HALF: load_data = {{16{half_fill}}, memory_data_in[15:0]};
            default:                load_data = memory_data_in;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/rv_control.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_config.svh"

module rv_control (
    input  wire                    clock,
    input  wire                    rst_n,
    input  wire                    memory_ready,
    input  wire [`RV_XLEN-1:0]     memory_data_in,
    output logic [`RV_XLEN-1:0]    memory_address,
    output logic                   memory_enable,
    output logic                   memory_operation,
    output logic [1:0]             memory_data_size,
    output logic [`RV_XLEN-1:0]    memory_data_out,
    output logic [`RV_XLEN-1:0]    instruction,
    input  rv_core_pkg::opcode_e   opcode,
    input  wire                    is_load,
    input  wire                    is_store,
    input  wire                    is_branch,
    input  wire                    writes_rd,
    input  rv_core_pkg::mem_size_e mem_size,
    input  wire [`RV_XLEN-1:0]     immediate,
    input  wire [`RV_XLEN-1:0]     alu_result,
    input  wire                    branch_taken,
    input  wire [`RV_XLEN-1:0]     rs1_data,
    input  wire [`RV_XLEN-1:0]     store_data,
    input  wire [`RV_XLEN-1:0]     load_data,
    output logic                   rd_write_enable,
    output logic [`RV_XLEN-1:0]    rd_write_data
);

    rv_core_pkg::core_state_e state;

    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] pc_step;
    logic [`RV_XLEN-1:0] pc_target;
    logic [`RV_XLEN-1:0] jalr_target;
    logic [`RV_XLEN-1:0] pc_next;
    logic [`RV_XLEN-1:0] exec_result;
    logic                is_mem;
    logic                fetch_start;
    logic                fetch_done;
    logic                exec_ready;
    logic                mem_done;

    assign is_mem      = is_load || is_store;
    assign fetch_start = (state == rv_core_pkg::ST_FETCH_REQ) && !memory_ready;
    assign fetch_done  = (state == rv_core_pkg::ST_FETCH_WAIT) && memory_ready;
    assign exec_ready  = (state == rv_core_pkg::ST_EXECUTE) && !memory_ready;
    assign mem_done    = (state == rv_core_pkg::ST_MEM_WAIT) && memory_ready;

    assign pc_step     = pc + `RV_INSTR_STEP;
    assign pc_target   = pc + immediate;
    assign jalr_target = rs1_data + immediate;

    always_comb begin
        if (opcode == rv_core_pkg::OPC_JAL || (is_branch && branch_taken)) begin
            pc_next = pc_target;
        end else if (opcode == rv_core_pkg::OPC_JALR) begin
            pc_next = {jalr_target[`RV_XLEN-1:1], 1'b0};
        end else begin
            pc_next = pc_step;
        end
    end

    always_comb begin
        case (opcode)
            rv_core_pkg::OPC_LUI:   exec_result = immediate;
            rv_core_pkg::OPC_AUIPC: exec_result = pc_target;
            rv_core_pkg::OPC_JAL,
            rv_core_pkg::OPC_JALR:  exec_result = pc_step; // Link address
            default:                exec_result = alu_result;
        endcase
    end

    assign rd_write_enable = (exec_ready && !is_mem && writes_rd) || (mem_done && is_load);
    assign rd_write_data   = is_load ? load_data : exec_result;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state         <= rv_core_pkg::ST_FETCH_REQ;
            pc            <= `RV_RESET_VECTOR;
            memory_enable <= 1'b0;
        end else begin
            case (state)
                rv_core_pkg::ST_FETCH_REQ: if (fetch_start) begin
                    memory_enable <= 1'b1;
                    state         <= rv_core_pkg::ST_FETCH_WAIT;
                end
                rv_core_pkg::ST_FETCH_WAIT: if (fetch_done) begin
                    memory_enable <= 1'b0;
                    state         <= rv_core_pkg::ST_EXECUTE;
                end
                rv_core_pkg::ST_EXECUTE: if (exec_ready) begin
                    if (is_mem) begin
                        memory_enable <= 1'b1;
                        state         <= rv_core_pkg::ST_MEM_WAIT;
                    end else begin
                        pc    <= pc_next;
                        state <= rv_core_pkg::ST_FETCH_REQ;
                    end
                end
                default: if (mem_done) begin
                    memory_enable <= 1'b0;
                    pc            <= pc_step;
                    state         <= rv_core_pkg::ST_FETCH_REQ;
                end
            endcase
        end
    end

    // Request fields, held while enable is high
    always_ff @(posedge clock) begin
        if (fetch_start) begin
            memory_address   <= pc;
            memory_operation <= 1'b0;
            memory_data_size <= rv_core_pkg::SIZE_WORD;
        end
        if (exec_ready && is_mem) begin
            memory_address   <= alu_result;
            memory_operation <= is_store;
            memory_data_size <= mem_size;
            memory_data_out  <= store_data;
        end
        if (fetch_done) begin
            instruction <= memory_data_in;
        end
    end

    enable_drops_on_ready: assert property (@(posedge clock) disable iff (!rst_n)
        (memory_enable && memory_ready) |=> !memory_enable);

endmodule

`default_nettype wire

// File: hw/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_config.svh"

module rv_core (
    input  wire                 clock,
    input  wire                 rst_n,
    output logic [`RV_XLEN-1:0] memory_address,
    output logic [`RV_XLEN-1:0] memory_data_out,
    input  wire [`RV_XLEN-1:0]  memory_data_in,
    output logic [1:0]          memory_data_size,
    output logic                memory_operation,
    output logic                memory_enable,
    input  wire                 memory_ready
);

    logic [`RV_XLEN-1:0]            instruction;
    rv_core_pkg::opcode_e           opcode;
    logic [`RV_REG_INDEX_WIDTH-1:0] rs1_index;
    logic [`RV_REG_INDEX_WIDTH-1:0] rs2_index;
    logic [`RV_REG_INDEX_WIDTH-1:0] rd_index;
    logic [2:0]                     funct3;
    logic [`RV_XLEN-1:0]            immediate;
    rv_core_pkg::alu_op_e           alu_op;
    logic                           alu_use_imm;
    logic                           writes_rd;
    logic                           is_load;
    logic                           is_store;
    logic                           is_branch;
    rv_core_pkg::mem_size_e         mem_size;
    logic                           load_unsigned;
    logic [`RV_XLEN-1:0]            rs1_data;
    logic [`RV_XLEN-1:0]            rs2_data;
    logic [`RV_XLEN-1:0]            alu_operand_b;
    logic [`RV_XLEN-1:0]            alu_result;
    logic                           branch_taken;
    logic [`RV_XLEN-1:0]            store_data;
    logic [`RV_XLEN-1:0]            load_data;
    logic                           rd_write_enable;
    logic [`RV_XLEN-1:0]            rd_write_data;

    assign alu_operand_b = alu_use_imm ? immediate : rs2_data;

    rv_decoder decoder_i (
        .instruction, .opcode, .rs1_index, .rs2_index, .rd_index, .funct3,
        .immediate, .alu_op, .alu_use_imm, .writes_rd, .is_load, .is_store,
        .is_branch, .mem_size, .load_unsigned
    );

    rv_regfile regfile_i (
        .clock, .rst_n, .rs1_index, .rs2_index, .rs1_data, .rs2_data,
        .write_enable(rd_write_enable), .rd_index, .rd_data(rd_write_data)
    );

    rv_alu alu_i (
        .operand_a(rs1_data), .operand_b(alu_operand_b), .alu_op, .funct3,
        .result(alu_result), .branch_taken
    );

    rv_lsu lsu_i (
        .mem_size, .load_unsigned, .store_source(rs2_data), .memory_data_in,
        .store_data, .load_data
    );

    rv_control control_i (
        .clock, .rst_n, .memory_ready, .memory_data_in, .memory_address,
        .memory_enable, .memory_operation, .memory_data_size, .memory_data_out,
        .instruction, .opcode, .is_load, .is_store, .is_branch, .writes_rd,
        .mem_size, .immediate, .alu_result, .branch_taken, .rs1_data,
        .store_data, .load_data, .rd_write_enable, .rd_write_data
    );

endmodule

`default_nettype wire

// File: sim/rv_core_tb_memory.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb_memory (
    input  wire         clock,
    input  wire         rst_n,
    input  wire  [31:0] memory_address,
    input  wire  [31:0] memory_data_out,
    output logic [31:0] memory_data_in,
    input  wire  [1:0]  memory_data_size,
    input  wire         memory_operation,
    input  wire         memory_enable,
    output logic        memory_ready,
    output logic        halt_fetched
);

    localparam logic [31:0] HALT_WORD = 32'h0000_006f; // jal x0, 0

    logic [7:0] mem_bytes [1024];
    integer     seed;
    int         draw;
    int         delay_left;
    logic       busy;

    initial begin
        seed           = 32'h26bc_6451;
        memory_ready   = 1'b0;
        memory_data_in = '0;
        halt_fetched   = 1'b0;
        busy           = 1'b0;
        delay_left     = 0;
    end

    task automatic fill();
        for (int i = 0; i < 1024; i++) begin
            mem_bytes[i] = i[7:0] ^ {4{i[9:8]}};
        end
    endtask

    task automatic write_word(input logic [31:0] address, input logic [31:0] data);
        for (int b = 0; b < 4; b++) begin
            mem_bytes[(address + b) & 32'h3ff] = data[8*b +: 8];
        end
    endtask

    function automatic logic [31:0] read_word(input logic [31:0] address);
        logic [31:0] word;
        for (int b = 0; b < 4; b++) begin
            word[8*b +: 8] = mem_bytes[(address + b) & 32'h3ff];
        end
        return word;
    endfunction

    task automatic complete_access();
        if (memory_operation) begin
            for (int b = 0; b < (1 << memory_data_size); b++) begin // 1, 2 or 4 bytes
                mem_bytes[(memory_address + b) & 32'h3ff] = memory_data_out[8*b +: 8];
            end
        end else begin
            memory_data_in <= read_word(memory_address);
            if (read_word(memory_address) == HALT_WORD) halt_fetched <= 1'b1;
        end
        memory_ready <= 1'b1;
    endtask

    always @(negedge clock or negedge rst_n) begin
        if (!rst_n) begin
            memory_ready <= 1'b0;
            halt_fetched <= 1'b0;
            busy         <= 1'b0;
        end else if (!memory_enable) begin
            memory_ready <= 1'b0;
            busy         <= 1'b0;
        end else if (!memory_ready && !busy) begin
            draw = $unsigned($random(seed)) % 4; // 0 to 3 cycles of delay
            if (draw == 0) begin
                complete_access();
            end else begin
                delay_left <= draw;
                busy       <= 1'b1;
            end
        end else if (busy && !memory_ready) begin
            if (delay_left == 1) complete_access();
            else delay_left <= delay_left - 1;
        end
    end

endmodule

`default_nettype wire

// File: sim/rv_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_config.svh"

module rv_core_tb;

    localparam logic [6:0] OPC_LOAD = 7'h03;
    localparam logic [6:0] OPC_OP_IMM = 7'h13;
    localparam logic [6:0] OPC_AUIPC = 7'h17;
    localparam logic [6:0] OPC_OP = 7'h33;
    localparam logic [6:0] OPC_LUI = 7'h37;
    localparam logic [6:0] OPC_JALR = 7'h67;

    logic        clock = 1'b0;
    logic        rst_n = 1'b0;
    logic [31:0] memory_address;
    logic [31:0] memory_data_out;
    logic [31:0] memory_data_in;
    logic [1:0]  memory_data_size;
    logic        memory_operation;
    logic        memory_enable;
    logic        memory_ready;
    logic        halt_fetched;

    integer      seed = 32'h26bc_6451;
    int          check_count = 0;
    int          mismatch_count = 0;
    int          failure_count = 0;
    logic [31:0] program_words [$];

    always #20 clock = ~clock;

    rv_core dut_i (
        .clock, .rst_n, .memory_address, .memory_data_out, .memory_data_in,
        .memory_data_size, .memory_operation, .memory_enable, .memory_ready
    );

    rv_core_tb_memory memory_i (
        .clock, .rst_n, .memory_address, .memory_data_out, .memory_data_in,
        .memory_data_size, .memory_operation, .memory_enable, .memory_ready,
        .halt_fetched
    );

    function automatic logic [31:0] r_type(int f7, int rs2, int rs1, int f3, int rd,
                                           logic [6:0] opc);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], opc};
    endfunction

    function automatic logic [31:0] i_type(int imm, int rs1, int f3, int rd, logic [6:0] opc);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
    endfunction

    function automatic logic [31:0] s_type(int imm, int rs2, int rs1, int f3);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] b_type(int imm, int rs2, int rs1, int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] u_type(int imm, int rd, logic [6:0] opc);
        return {imm[19:0], rd[4:0], opc};
    endfunction

    function automatic logic [31:0] j_type(int imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
    endfunction

    function automatic void emit(logic [31:0] word);
        program_words.push_back(word);
    endfunction

    // LUI plus ADDI, upper part rounded for the sign of the low 12 bits
    function automatic void load_constant(int rd, logic [31:0] value);
        logic [31:0] upper;
        upper = (value + 32'h800) >> 12;
        emit(u_type(upper, rd, OPC_LUI));
        emit(i_type(value[11:0], rd, 0, rd, OPC_OP_IMM));
    endfunction

    function automatic void store_from(int f3, int rs2, int offset);
        emit(s_type(offset, rs2, 10, f3)); // x10 holds the data area base
    endfunction

    function automatic logic [31:0] alu_reference(int f3, int alt, logic [31:0] a,
                                                  logic [31:0] b);
        case (f3)
            0: return (alt != 0) ? a - b : a + b;
            1: return a << b[4:0];
            2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3: return (a < b) ? 32'd1 : 32'd0;
            4: return a ^ b;
            5: return (a >> b[4:0]) | ((alt != 0 && a[31]) ? ~(32'hffff_ffff >> b[4:0]) : 32'd0);
            6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [31:0] extend_load(int f3, logic [31:0] field);
        case (f3)
            0: return {{24{field[7]}}, field[7:0]};
            1: return {{16{field[15]}}, field[15:0]};
            4: return {24'b0, field[7:0]};
            5: return {16'b0, field[15:0]};
            default: return field;
        endcase
    endfunction

    function automatic logic branch_decision(int f3, logic [31:0] x, logic [31:0] y);
        case (f3)
            0: return x == y;
            1: return x != y;
            4: return $signed(x) < $signed(y);
            5: return $signed(x) >= $signed(y);
            6: return x < y;
            default: return x >= y;
        endcase
    endfunction

    task automatic check_word(input logic [31:0] address, input logic [31:0] expected,
                              input string what);
        logic [31:0] actual;
        actual = memory_i.read_word(address);
        check_count++;
        if (actual !== expected) begin
            $display("mismatch at %0d ns: %s at 0x%03h reads 0x%08h, expected 0x%08h",
                     $time, what, address, actual, expected);
            mismatch_count++;
        end
    endtask

    // Load the program under reset, release, then run to the halt word
    task automatic run_program();
        int cycles;
        int limit;
        emit(j_type(0, 0));
        limit = program_words.size() * 10;
        @(negedge clock);
        rst_n = 1'b0;
        memory_i.fill();
        foreach (program_words[i]) memory_i.write_word(4 * i, program_words[i]);
        repeat (2) @(negedge clock);
        rst_n = 1'b1;
        if (memory_enable !== 1'b0) begin
            $display("Error at %0d ns: memory_enable is high right after reset", $time);
            failure_count++;
        end
        cycles = 0;
        while (memory_enable !== 1'b1 && cycles < 10) begin
            @(negedge clock);
            cycles++;
        end
        check_count++;
        if (memory_enable !== 1'b1) begin
            $display("Error at %0d ns: core started no fetch after reset", $time);
            failure_count++;
        end else if (memory_address !== `RV_RESET_VECTOR || memory_operation !== 1'b0
                     || memory_data_size !== 2'd2) begin
            $display("mismatch at %0d ns: first access is addr 0x%08h op %0d size %0d",
                     $time, memory_address, memory_operation, memory_data_size);
            mismatch_count++;
        end
        while (!halt_fetched && cycles < limit) begin
            @(negedge clock);
            cycles++;
        end
        if (!halt_fetched) begin
            $display("Timeout at %0d ns: halt word not fetched within %0d cycles", $time, limit);
            failure_count++;
        end
        program_words.delete();
    endtask

    task automatic test_alu_ops();
        int          r_f3 [10] = '{0, 0, 2, 3, 4, 6, 7, 1, 5, 5};
        int          r_alt [10] = '{0, 1, 0, 0, 0, 0, 0, 0, 0, 1};
        int          i_f3 [9] = '{0, 2, 3, 4, 6, 7, 1, 5, 5};
        logic [31:0] a;
        logic [31:0] b;
        logic [11:0] imm [9];
        a = $random(seed) | 32'h8000_0000; // Negative, so SLT and SLTU differ
        b = $random(seed) & 32'h7fff_ffff;
        load_constant(1, a);
        load_constant(2, b);
        emit(i_type(32'h200, 0, 0, 10, OPC_OP_IMM));
        for (int k = 0; k < 10; k++) begin
            emit(r_type((r_alt[k] != 0) ? 32 : 0, 2, 1, r_f3[k], 3, OPC_OP));
            store_from(2, 3, 4 * k);
        end
        for (int k = 0; k < 9; k++) begin
            imm[k] = 12'($random(seed));
            if (i_f3[k] == 1 || i_f3[k] == 5) begin
                imm[k] = {1'b0, k == 8, 5'b0, imm[k][4:0]}; // Bit 10 selects SRAI
            end
            emit(i_type(imm[k], 1, i_f3[k], 3, OPC_OP_IMM));
            store_from(2, 3, 40 + 4 * k);
        end
        run_program();
        for (int k = 0; k < 10; k++) begin
            check_word(32'h200 + 4 * k, alu_reference(r_f3[k], r_alt[k], a, b), "OP result");
        end
        for (int k = 0; k < 9; k++) begin
            check_word(32'h228 + 4 * k, alu_reference(i_f3[k], k == 8, a,
                       {{20{imm[k][11]}}, imm[k]}), "OP-IMM result");
        end
    endtask

    task automatic test_upper_and_partial();
        logic [19:0] lui_imm;
        logic [19:0] auipc_imm;
        logic [31:0] auipc_pc;
        logic [31:0] words [3];
        logic [31:0] byte_value;
        logic [31:0] half_value;
        lui_imm = 20'($random(seed));
        auipc_imm = 20'($random(seed));
        emit(i_type(32'h200, 0, 0, 10, OPC_OP_IMM));
        emit(u_type(lui_imm, 5, OPC_LUI));
        store_from(2, 5, 0);
        auipc_pc = program_words.size() * 4;
        emit(u_type(auipc_imm, 6, OPC_AUIPC));
        store_from(2, 6, 4);
        for (int k = 0; k < 3; k++) begin
            words[k] = $random(seed);
            load_constant(11, words[k]);
            store_from(2, 11, 32 + 4 * k);
        end
        byte_value = $random(seed);
        half_value = $random(seed);
        load_constant(7, byte_value);
        load_constant(8, half_value);
        store_from(0, 7, 32'h21); // SB into byte 1
        store_from(1, 8, 32'h26); // SH into the upper half
        run_program();
        check_word(32'h200, {lui_imm, 12'b0}, "LUI result");
        check_word(32'h204, auipc_pc + {auipc_imm, 12'b0}, "AUIPC result");
        check_word(32'h220, {words[0][31:16], byte_value[7:0], words[0][7:0]}, "SB word");
        check_word(32'h224, {half_value[15:0], words[1][15:0]}, "SH word");
        check_word(32'h228, words[2], "word after SH");
    endtask

    task automatic test_loads();
        int          load_f3 [7] = '{0, 0, 4, 1, 1, 5, 2};
        int          load_offset [7] = '{0, 1, 3, 0, 2, 2, 0};
        logic [31:0] pattern;
        pattern = $random(seed) | 32'h8080_8080; // Top bit set in every byte
        emit(i_type(32'h200, 0, 0, 10, OPC_OP_IMM));
        load_constant(11, pattern);
        store_from(2, 11, 32'h40);
        for (int k = 0; k < 7; k++) begin
            emit(i_type(32'h40 + load_offset[k], 10, load_f3[k], 12, OPC_LOAD));
            store_from(2, 12, 32'h50 + 4 * k);
        end
        run_program();
        for (int k = 0; k < 7; k++) begin
            check_word(32'h250 + 4 * k, extend_load(load_f3[k], pattern >> (8 * load_offset[k])),
                       "load result");
        end
    endtask

    task automatic test_branches_and_jumps();
        int          branch_f3 [6] = '{0, 1, 4, 5, 6, 7};
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] jal_pc;
        int          jalr_index;
        int          slot;
        a = $random(seed) | 32'h8000_0000;
        b = $random(seed) & 32'h7fff_ffff;
        emit(i_type(32'h200, 0, 0, 10, OPC_OP_IMM));
        load_constant(1, a);
        load_constant(2, b);
        load_constant(3, a);
        for (int p = 0; p < 2; p++) begin
            for (int k = 0; k < 6; k++) begin
                slot = 6 * p + k;
                store_from(2, 0, 4 * slot);
                emit(i_type(slot + 1, 0, 0, 4, OPC_OP_IMM));
                emit(b_type(8, (p == 0) ? 2 : 3, 1, branch_f3[k])); // Taken skips the marker
                store_from(2, 4, 4 * slot);
            end
        end
        jal_pc = program_words.size() * 4;
        emit(j_type(8, 5));
        emit(i_type(1, 0, 0, 6, OPC_OP_IMM));
        store_from(2, 5, 32'h30);
        jalr_index = program_words.size();
        emit(i_type(4 * (jalr_index + 3) + 1, 0, 0, 7, OPC_OP_IMM)); // Odd target address
        emit(i_type(0, 7, 0, 8, OPC_JALR));
        emit(i_type(2, 0, 0, 6, OPC_OP_IMM));
        store_from(2, 8, 32'h34);
        store_from(2, 6, 32'h38);
        run_program();
        for (int p = 0; p < 2; p++) begin
            for (int k = 0; k < 6; k++) begin
                slot = 6 * p + k;
                check_word(32'h200 + 4 * slot,
                           branch_decision(branch_f3[k], a, (p == 0) ? b : a) ? 32'd0 : slot + 1,
                           "branch marker");
            end
        end
        check_word(32'h230, jal_pc + 4, "JAL link");
        check_word(32'h234, 4 * (jalr_index + 2), "JALR link");
        check_word(32'h238, 32'd0, "skipped instructions");
    endtask

    task automatic test_zero_register();
        load_constant(1, $random(seed) | 32'h1);
        emit(i_type(123, 0, 0, 0, OPC_OP_IMM));
        emit(r_type(0, 1, 1, 0, 0, OPC_OP));
        emit(u_type(20'habcde, 0, OPC_LUI));
        emit(i_type(32'h200, 0, 0, 10, OPC_OP_IMM));
        store_from(2, 0, 32'h60);
        run_program();
        check_word(32'h260, 32'd0, "x0 store");
    endtask

    initial begin
        test_alu_ops();
        test_upper_and_partial();
        test_loads();
        test_branches_and_jumps();
        test_zero_register();
        $display("Checks: %0d, mismatches: %0d, other failures: %0d",
                 check_count, mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rv_core.f
+incdir+include
hw/rv_core_pkg.sv
hw/rv_decoder.sv
hw/rv_regfile.sv
hw/rv_alu.sv
hw/rv_lsu.sv
hw/rv_control.sv
hw/rv_core.sv
sim/rv_core_tb_memory.sv
sim/rv_core_tb.sv

// File: Bender.yml
package:
  name: rv_core

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/rv_core_pkg.sv
      - hw/rv_decoder.sv
      - hw/rv_regfile.sv
      - hw/rv_alu.sv
      - hw/rv_lsu.sv
      - hw/rv_control.sv
      - hw/rv_core.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/rv_core_tb_memory.sv
      - sim/rv_core_tb.sv
